/* common/median_defines.svh */
`ifndef MEDIAN_DEFINES_SVH
`define MEDIAN_DEFINES_SVH

// sample word and window length
`define MED_SAMPLE_W 8
`define MED_TAPS 7

// samples per frame, 8 or more
`define MED_FRAME_LEN 32

// sort strobe to sorter done, in cycles
`define MED_SORT_LAT 9

// run counter width, holds frame and flush counts
`define MED_CNT_W ($clog2(`MED_FRAME_LEN + `MED_SORT_LAT + 1))

`endif

/* common/median_data_pkg.sv */
`include "median_defines.svh"

package median_data_pkg;

  // one unsigned pixel sample
  typedef logic [`MED_SAMPLE_W-1:0] sample_t;

  // sliding window, index 0 is the oldest sample
  typedef sample_t window_t [`MED_TAPS];

endpackage

/* common/median_ctrl_pkg.sv */
package median_ctrl_pkg;

  // frame controller states
  //   IDLE  waiting for start
  //   FILL  first six samples of a frame, no sort yet
  //   RUN   every accepted sample starts a sort
  //   FLUSH pipeline drains before frame done
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FILL  = 2'd1,
    RUN   = 2'd2,
    FLUSH = 2'd3
  } ctrl_state_e;

endpackage

/* common/median_ifs.sv */
`timescale 1ns/1ps

// window handed to the sorter, strobe marks a new sort
interface window_if;
  median_data_pkg::window_t win;
  logic                     sort_go;

  modport window (output win, output sort_go);
  modport sorter (input win, input sort_go);
endinterface

// ascending sort result, done travels with the data
interface sorted_if;
  median_data_pkg::sample_t min;
  median_data_pkg::sample_t out2;
  median_data_pkg::sample_t out3;
  median_data_pkg::sample_t mid;
  median_data_pkg::sample_t out5;
  median_data_pkg::sample_t out6;
  median_data_pkg::sample_t max;
  logic                     done;

  modport source (output min, out2, out3, mid, out5, out6, max, done);
  modport sink (input min, out2, out3, mid, out5, out6, max, done);
endinterface

/* sorter/sorting_network.sv */
`timescale 1ns/1ps

module sorting_network (
  input  median_data_pkg::sample_t s1_i,
  input  median_data_pkg::sample_t s2_i,
  input  median_data_pkg::sample_t s3_i,
  output median_data_pkg::sample_t min_o,
  output median_data_pkg::sample_t med_o,
  output median_data_pkg::sample_t max_o
);

  median_data_pkg::sample_t a_lo, a_hi, b_lo;

  // first pair
  assign a_lo = (s1_i < s2_i) ? s1_i : s2_i;
  assign a_hi = (s1_i < s2_i) ? s2_i : s1_i;

  // larger one against the third, max settles here
  assign b_lo  = (a_hi < s3_i) ? a_hi : s3_i;
  assign max_o = (a_hi < s3_i) ? s3_i : a_hi;

  // remaining two
  assign min_o = (a_lo < b_lo) ? a_lo : b_lo;
  assign med_o = (a_lo < b_lo) ? b_lo : a_lo;

endmodule

/* sorter/sort_ascending_5.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module sort_ascending_5 (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     done_i,
  input  median_data_pkg::sample_t s1_i,
  input  median_data_pkg::sample_t s2_i,
  input  median_data_pkg::sample_t s3_i,
  input  median_data_pkg::sample_t s4_i,
  input  median_data_pkg::sample_t s5_i,
  output median_data_pkg::sample_t min_o,
  output median_data_pkg::sample_t out2_o,
  output median_data_pkg::sample_t mid_o,
  output median_data_pkg::sample_t out4_o,
  output median_data_pkg::sample_t max_o,
  output logic                     done_o
);

  median_data_pkg::sample_t c1 [5];
  median_data_pkg::sample_t c2 [5];
  median_data_pkg::sample_t c3 [5];
  median_data_pkg::sample_t r1 [5];
  median_data_pkg::sample_t r2 [5];
  median_data_pkg::sample_t r3 [5];
  logic [2:0]               done_q;

  // compare-exchange, returns {low, high}
  function automatic logic [2*`MED_SAMPLE_W-1:0] cx(input median_data_pkg::sample_t a,
                                                     input median_data_pkg::sample_t b);
    return (a > b) ? {b, a} : {a, b};
  endfunction

  // layers 1 and 2
  always_comb begin
    c1 = '{s1_i, s2_i, s3_i, s4_i, s5_i};
    {c1[0], c1[3]} = cx(c1[0], c1[3]);
    {c1[1], c1[4]} = cx(c1[1], c1[4]);
    {c1[0], c1[2]} = cx(c1[0], c1[2]);
    {c1[1], c1[3]} = cx(c1[1], c1[3]);
  end

  // layers 3 and 4
  always_comb begin
    c2 = r1;
    {c2[0], c2[1]} = cx(c2[0], c2[1]);
    {c2[2], c2[4]} = cx(c2[2], c2[4]);
    {c2[1], c2[2]} = cx(c2[1], c2[2]);
    {c2[3], c2[4]} = cx(c2[3], c2[4]);
  end

  // last layer, middle pair only
  always_comb begin
    c3 = r2;
    {c3[2], c3[3]} = cx(c3[2], c3[3]);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r1     <= '{default: '0};
      r2     <= '{default: '0};
      r3     <= '{default: '0};
      done_q <= '0;
    end else begin
      r1     <= c1;
      r2     <= c2;
      r3     <= c3;
      done_q <= {done_q[1:0], done_i};
    end
  end

  assign min_o  = r3[0];
  assign out2_o = r3[1];
  assign mid_o  = r3[2];
  assign out4_o = r3[3];
  assign max_o  = r3[4];
  assign done_o = done_q[2];

endmodule

/* sorter/sort_ascending_7.sv */
`timescale 1ns/1ps

module sort_ascending_7 (
  input  logic     clk,
  input  logic     rst_n,
  window_if.sorter sort_if,
  sorted_if.source res_if
);

  median_data_pkg::sample_t sa1_min, sa1_out2, sa1_mid, sa1_out4, sa1_max;
  logic                     sa1_done;
  median_data_pkg::sample_t p1_mid, p1_out4, p1_max;
  logic                     p1_done;
  // newest pair waits out sa1 and p1
  median_data_pkg::sample_t s6_d [4];
  median_data_pkg::sample_t s7_d [4];
  // lowest pair of sa1 waits out p1, sa2 and p2
  median_data_pkg::sample_t lo1_d [5];
  median_data_pkg::sample_t lo2_d [5];
  median_data_pkg::sample_t sa2_min, sa2_out2, sa2_mid, sa2_out4, sa2_max;
  logic                     sa2_done;
  median_data_pkg::sample_t p2_min, p2_out2, p2_mid, p2_out4, p2_max;
  logic                     p2_done;
  median_data_pkg::sample_t sn1_min, sn1_med, sn1_max;
  median_data_pkg::sample_t p3_sn1_min, p3_sn1_med, p3_sn1_max;
  median_data_pkg::sample_t p3_out2, p3_mid, p3_out4, p3_max;
  logic                     p3_done;

  // five oldest samples
  sort_ascending_5 u_sa1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .done_i (sort_if.sort_go),
    .s1_i   (sort_if.win[0]),
    .s2_i   (sort_if.win[1]),
    .s3_i   (sort_if.win[2]),
    .s4_i   (sort_if.win[3]),
    .s5_i   (sort_if.win[4]),
    .min_o  (sa1_min),
    .out2_o (sa1_out2),
    .mid_o  (sa1_mid),
    .out4_o (sa1_out4),
    .max_o  (sa1_max),
    .done_o (sa1_done)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_mid  <= '0;
      p1_out4 <= '0;
      p1_max  <= '0;
      p1_done <= 1'b0;
      s6_d    <= '{default: '0};
      s7_d    <= '{default: '0};
      lo1_d   <= '{default: '0};
      lo2_d   <= '{default: '0};
    end else begin
      p1_mid   <= sa1_mid;
      p1_out4  <= sa1_out4;
      p1_max   <= sa1_max;
      p1_done  <= sa1_done;
      s6_d[0]  <= sort_if.win[5];
      s7_d[0]  <= sort_if.win[6];
      lo1_d[0] <= sa1_min;
      lo2_d[0] <= sa1_out2;
      for (int i = 1; i < 4; i++) begin
        s6_d[i] <= s6_d[i-1];
        s7_d[i] <= s7_d[i-1];
      end
      for (int i = 1; i < 5; i++) begin
        lo1_d[i] <= lo1_d[i-1];
        lo2_d[i] <= lo2_d[i-1];
      end
    end
  end

  // newest two against the upper three of sa1
  sort_ascending_5 u_sa2 (
    .clk    (clk),
    .rst_n  (rst_n),
    .done_i (p1_done),
    .s1_i   (s6_d[3]),
    .s2_i   (s7_d[3]),
    .s3_i   (p1_max),
    .s4_i   (p1_out4),
    .s5_i   (p1_mid),
    .min_o  (sa2_min),
    .out2_o (sa2_out2),
    .mid_o  (sa2_mid),
    .out4_o (sa2_out4),
    .max_o  (sa2_max),
    .done_o (sa2_done)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p2_min  <= '0;
      p2_out2 <= '0;
      p2_mid  <= '0;
      p2_out4 <= '0;
      p2_max  <= '0;
      p2_done <= 1'b0;
    end else begin
      p2_min  <= sa2_min;
      p2_out2 <= sa2_out2;
      p2_mid  <= sa2_mid;
      p2_out4 <= sa2_out4;
      p2_max  <= sa2_max;
      p2_done <= sa2_done;
    end
  end

  // the top three of sa2 are already final
  sorting_network u_sn1 (
    .s1_i  (lo1_d[4]),
    .s2_i  (lo2_d[4]),
    .s3_i  (p2_min),
    .min_o (sn1_min),
    .med_o (sn1_med),
    .max_o (sn1_max)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p3_sn1_min <= '0;
      p3_sn1_med <= '0;
      p3_sn1_max <= '0;
      p3_out2    <= '0;
      p3_mid     <= '0;
      p3_out4    <= '0;
      p3_max     <= '0;
      p3_done    <= 1'b0;
    end else begin
      p3_sn1_min <= sn1_min;
      p3_sn1_med <= sn1_med;
      p3_sn1_max <= sn1_max;
      p3_out2    <= p2_out2;
      p3_mid     <= p2_mid;
      p3_out4    <= p2_out4;
      p3_max     <= p2_max;
      p3_done    <= p2_done;
    end
  end

  // ranks 2 to 4, combinational after p3
  sorting_network u_sn2 (
    .s1_i  (p3_sn1_med),
    .s2_i  (p3_sn1_max),
    .s3_i  (p3_out2),
    .min_o (res_if.out2),
    .med_o (res_if.out3),
    .max_o (res_if.mid)
  );

  assign res_if.min  = p3_sn1_min;
  assign res_if.out5 = p3_mid;
  assign res_if.out6 = p3_out4;
  assign res_if.max  = p3_max;
  assign res_if.done = p3_done;

endmodule

/* source/run_counter.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module run_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load_i,
  input  logic [`MED_CNT_W-1:0] load_val_i,
  input  logic                  dec_i,
  output logic                  zero_o
);

  logic [`MED_CNT_W-1:0] cnt_q;

  // load wins over decrement
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= load_val_i;
    end else if (dec_i && !zero_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // holds at zero until the next load
  assign zero_o = (cnt_q == '0);

endmodule

/* source/sample_window.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module sample_window (
  input  logic                     clk,
  input  logic                     rst_n,
  input  median_data_pkg::sample_t sample_i,
  input  logic                     shift_i,
  input  logic                     emit_i,
  window_if.window                 win_if
);

  median_data_pkg::window_t win_q;
  logic                     go_q;

  // oldest sample drops out of slot 0
  always_ff @(posedge clk) begin
    if (shift_i) begin
      for (int i = 0; i < `MED_TAPS - 1; i++) begin
        win_q[i] <= win_q[i+1];
      end
      win_q[`MED_TAPS-1] <= sample_i;
    end
  end

  // strobe leaves with the window it belongs to
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      go_q <= 1'b0;
    end else begin
      go_q <= shift_i && emit_i;
    end
  end

  assign win_if.win     = win_q;
  assign win_if.sort_go = go_q;

endmodule

/* source/filter_ctrl.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module filter_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  logic                  sample_valid_i,
  output logic                  shift_o,
  output logic                  emit_o,
  output logic                  cnt_load_o,
  output logic [`MED_CNT_W-1:0] cnt_val_o,
  output logic                  cnt_dec_o,
  input  logic                  cnt_zero_i,
  output logic                  frame_done_o,
  output logic                  busy_o
);

  localparam int CNT_W = `MED_CNT_W;

  median_ctrl_pkg::ctrl_state_e state_q, state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= median_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // samples only count while filling or running
  assign shift_o = sample_valid_i &&
                   (state_q == median_ctrl_pkg::FILL || state_q == median_ctrl_pkg::RUN);

  // six samples in, the next one completes a window
  assign emit_o = (state_q == median_ctrl_pkg::RUN) ||
                  (state_q == median_ctrl_pkg::FILL && cnt_zero_i);

  // flush timer runs every cycle
  assign cnt_dec_o    = shift_o || (state_q == median_ctrl_pkg::FLUSH);
  assign frame_done_o = (state_q == median_ctrl_pkg::FLUSH) && cnt_zero_i;
  assign busy_o       = (state_q != median_ctrl_pkg::IDLE);

  always_comb begin
    state_d    = state_q;
    cnt_load_o = 1'b0;
    cnt_val_o  = '0;
    case (state_q)
      median_ctrl_pkg::IDLE: begin
        if (start_i) begin
          cnt_load_o = 1'b1;
          cnt_val_o  = CNT_W'(`MED_TAPS - 1);
          state_d    = median_ctrl_pkg::FILL;
        end
      end
      median_ctrl_pkg::FILL: begin
        // 7th sample, count what is left after it
        if (shift_o && cnt_zero_i) begin
          cnt_load_o = 1'b1;
          cnt_val_o  = CNT_W'(`MED_FRAME_LEN - `MED_TAPS - 1);
          state_d    = median_ctrl_pkg::RUN;
        end
      end
      median_ctrl_pkg::RUN: begin
        // last sample, wait for its result plus one cycle
        if (shift_o && cnt_zero_i) begin
          cnt_load_o = 1'b1;
          cnt_val_o  = CNT_W'(`MED_SORT_LAT + 1);
          state_d    = median_ctrl_pkg::FLUSH;
        end
      end
      median_ctrl_pkg::FLUSH: begin
        if (cnt_zero_i) begin
          state_d = median_ctrl_pkg::IDLE;
        end
      end
    endcase
  end

endmodule

/* source/median_filter_top.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module median_filter_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  median_data_pkg::sample_t sample_i,
  input  logic                     sample_valid_i,
  output median_data_pkg::sample_t median_o,
  output median_data_pkg::sample_t min_o,
  output median_data_pkg::sample_t max_o,
  output logic                     result_valid_o,
  output logic                     frame_done_o,
  output logic                     busy_o
);

  logic                  shift;
  logic                  emit;
  logic                  cnt_load;
  logic [`MED_CNT_W-1:0] cnt_val;
  logic                  cnt_dec;
  logic                  cnt_zero;

  window_if u_win_if ();
  sorted_if u_res_if ();

  filter_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .sample_valid_i (sample_valid_i),
    .shift_o        (shift),
    .emit_o         (emit),
    .cnt_load_o     (cnt_load),
    .cnt_val_o      (cnt_val),
    .cnt_dec_o      (cnt_dec),
    .cnt_zero_i     (cnt_zero),
    .frame_done_o   (frame_done_o),
    .busy_o         (busy_o)
  );

  // one counter for fill, frame and flush
  run_counter u_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (cnt_load),
    .load_val_i (cnt_val),
    .dec_i      (cnt_dec),
    .zero_o     (cnt_zero)
  );

  sample_window u_window (
    .clk      (clk),
    .rst_n    (rst_n),
    .sample_i (sample_i),
    .shift_i  (shift),
    .emit_i   (emit),
    .win_if   (u_win_if)
  );

  sort_ascending_7 u_sort (
    .clk     (clk),
    .rst_n   (rst_n),
    .sort_if (u_win_if),
    .res_if  (u_res_if)
  );

  // middle rank of seven is the median
  assign median_o       = u_res_if.mid;
  assign min_o          = u_res_if.min;
  assign max_o          = u_res_if.max;
  assign result_valid_o = u_res_if.done;

endmodule

/* sim/tb_median_filter.sv */
`timescale 1ns/1ps
`include "median_defines.svh"

module tb_median_filter;

  localparam int NUM_FRAMES    = 20;
  localparam int RESULTS_FRAME = `MED_FRAME_LEN - `MED_TAPS + 1;
  localparam int LATENCY       = `MED_SORT_LAT + 1;
  // worst case gaps of 3 plus start, flush and idle cycles per frame
  localparam int WATCHDOG_CYC  = 16 + NUM_FRAMES * (4 * `MED_FRAME_LEN + `MED_SORT_LAT + 24);

  typedef struct packed {
    median_data_pkg::sample_t med;
    median_data_pkg::sample_t mn;
    median_data_pkg::sample_t mx;
  } window_stats_t;

  logic                     clk;
  logic                     rst_n;
  logic                     start_i;
  median_data_pkg::sample_t sample_i;
  logic                     sample_valid_i;
  median_data_pkg::sample_t median_o;
  median_data_pkg::sample_t min_o;
  median_data_pkg::sample_t max_o;
  logic                     result_valid_o;
  logic                     frame_done_o;
  logic                     busy_o;

  logic [31:0]              rng_state;
  int                       edge_count;
  int                       result_count;
  int                       last_result_edge;
  int                       frames_done;
  median_data_pkg::sample_t win_model [$];
  window_stats_t            stats_q [$];
  int                       trig_q [$];

  median_filter_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .median_o       (median_o),
    .min_o          (min_o),
    .max_o          (max_o),
    .result_valid_o (result_valid_o),
    .frame_done_o   (frame_done_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_rand(output logic [31:0] r);
    rng_state = lcg_next(rng_state);
    r         = rng_state;
  endtask

  // min, median and max of one window by a plain bubble sort
  function automatic window_stats_t ref_sort7(input median_data_pkg::window_t w);
    median_data_pkg::sample_t s [`MED_TAPS];
    median_data_pkg::sample_t t;
    window_stats_t            r;
    for (int i = 0; i < `MED_TAPS; i++) begin
      s[i] = w[i];
    end
    for (int i = 0; i < `MED_TAPS - 1; i++) begin
      for (int j = 0; j < `MED_TAPS - 1 - i; j++) begin
        if (s[j] > s[j+1]) begin
          t      = s[j];
          s[j]   = s[j+1];
          s[j+1] = t;
        end
      end
    end
    r.mn  = s[0];
    r.med = s[(`MED_TAPS - 1) / 2];
    r.mx  = s[`MED_TAPS - 1];
    return r;
  endfunction

  // sample driven now is taken on the next rising edge
  task automatic model_accept(input median_data_pkg::sample_t s);
    median_data_pkg::window_t w;
    win_model.push_back(s);
    if (win_model.size() > `MED_TAPS) begin
      void'(win_model.pop_front());
    end
    if (win_model.size() == `MED_TAPS) begin
      for (int i = 0; i < `MED_TAPS; i++) begin
        w[i] = win_model[i];
      end
      stats_q.push_back(ref_sort7(w));
      trig_q.push_back(edge_count + 1);
    end
  endtask

  task automatic drive_frame(input bit use_gaps);
    logic [31:0] r;
    int          gap;
    start_i        = 1'b1;
    sample_valid_i = 1'b0;
    @(negedge clk);
    start_i = 1'b0;
    win_model.delete();
    for (int n = 0; n < `MED_FRAME_LEN; n++) begin
      draw_rand(r);
      gap = use_gaps ? int'(r[17:16]) : 0;
      // idle cycles where start must be ignored
      repeat (gap) begin
        draw_rand(r);
        sample_valid_i = 1'b0;
        sample_i       = r[31:24];
        start_i        = r[20];
        @(negedge clk);
      end
      draw_rand(r);
      start_i        = 1'b0;
      sample_valid_i = 1'b1;
      sample_i       = r[31:24];
      model_accept(r[31:24]);
      @(negedge clk);
    end
    sample_valid_i = 1'b0;
  endtask

  // samples and start during the flush go nowhere
  task automatic flush_noise();
    logic [31:0] r;
    check_val("busy_o", 32'(busy_o), 32'd1);
    for (int i = 0; i < 4; i++) begin
      draw_rand(r);
      sample_i       = r[31:24];
      sample_valid_i = 1'b1;
      start_i        = i[0];
      @(negedge clk);
      check_val("busy_o", 32'(busy_o), 32'd1);
    end
    sample_valid_i = 1'b0;
    start_i        = 1'b0;
  endtask

  task automatic idle_noise(input int frames_expected);
    logic [31:0] r;
    while (frames_done < frames_expected) begin
      @(negedge clk);
    end
    check_val("busy_o", 32'(busy_o), 32'd0);
    for (int i = 0; i < 3; i++) begin
      draw_rand(r);
      sample_i       = r[31:24];
      sample_valid_i = 1'b1;
      @(negedge clk);
      check_val("busy_o", 32'(busy_o), 32'd0);
    end
    sample_valid_i = 1'b0;
  endtask

  // scoreboard sees the outputs as they were just before each edge
  initial begin
    window_stats_t exp_stats;
    int            trig;
    edge_count       = 0;
    result_count     = 0;
    last_result_edge = 0;
    frames_done      = 0;
    forever begin
      @(posedge clk);
      edge_count = edge_count + 1;
      if (rst_n && result_valid_o) begin
        if (stats_q.size() == 0) begin
          report_error("result_valid_o rose with no window pending");
        end else begin
          exp_stats = stats_q.pop_front();
          trig      = trig_q.pop_front();
          check_val("median_o", 32'(median_o), 32'(exp_stats.med));
          check_val("min_o", 32'(min_o), 32'(exp_stats.mn));
          check_val("max_o", 32'(max_o), 32'(exp_stats.mx));
          check_val("result latency", edge_count - trig, 32'(LATENCY));
          result_count     = result_count + 1;
          last_result_edge = edge_count;
        end
      end
      if (rst_n && frame_done_o) begin
        check_val("results per frame", 32'(result_count), 32'(RESULTS_FRAME));
        check_val("frame_done_o edge", edge_count, last_result_edge + 1);
        frames_done  = frames_done + 1;
        result_count = 0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    report_error("timeout, the frames did not complete in the expected time");
  end

  initial begin
    rst_n          = 1'b0;
    start_i        = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    rng_state      = 32'hd8d2_5f92;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    check_val("result_valid_o", 32'(result_valid_o), 32'd0);
    check_val("frame_done_o", 32'(frame_done_o), 32'd0);
    check_val("busy_o", 32'(busy_o), 32'd0);
    // every fourth frame runs without gaps
    for (int f = 0; f < NUM_FRAMES; f++) begin
      drive_frame(f % 4 != 0);
      flush_noise();
      idle_noise(f + 1);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/median_data_pkg.sv
common/median_ctrl_pkg.sv
common/median_ifs.sv
sorter/sorting_network.sv
sorter/sort_ascending_5.sv
sorter/sort_ascending_7.sv
source/run_counter.sv
source/sample_window.sv
source/filter_ctrl.sv
source/median_filter_top.sv
sim/tb_median_filter.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_median_filter
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
